/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // **************************************************
    // op codes
    // **************************************************
    localparam int OP_W = 4;

    localparam logic [OP_W-1:0] OP_NOP   = 4'd0;
    localparam logic [OP_W-1:0] OP_LD_B  = 4'd1;
    localparam logic [OP_W-1:0] OP_LD_BU = 4'd2;
    localparam logic [OP_W-1:0] OP_LD_H  = 4'd3;
    localparam logic [OP_W-1:0] OP_LD_HU = 4'd4;
    localparam logic [OP_W-1:0] OP_LD_W  = 4'd5;
    localparam logic [OP_W-1:0] OP_ST_B  = 4'd6;
    localparam logic [OP_W-1:0] OP_ST_H  = 4'd7;
    localparam logic [OP_W-1:0] OP_ST_W  = 4'd8;
    localparam logic [OP_W-1:0] OP_LL    = 4'd9;
    localparam logic [OP_W-1:0] OP_SC    = 4'd10;

    // **************************************************
    // exception vector bits
    // **************************************************
    localparam int EXCP_W = 6;

    localparam int EXCP_ALE  = 0;
    localparam int EXCP_TLBR = 1;
    localparam int EXCP_PME  = 2;
    localparam int EXCP_PPI  = 3;
    localparam int EXCP_PIS  = 4;
    localparam int EXCP_PIL  = 5;

    // dmw csr fields.
    localparam int DMW_PLV0     = 0;
    localparam int DMW_PLV3     = 3;
    localparam int DMW_PSEG_LSB = 25; // 3 bits.
    localparam int DMW_VSEG_LSB = 29; // 3 bits.

    // lane 3 and half 1 are the high-order bits.
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

`default_nettype wire

/* verilog/data_tlb.sv */
`default_nettype none

module data_tlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] idx_i,
    input  logic [19:0]                    vppn_i,
    input  logic [19:0]                    ppn_i,
    input  logic                           v_i,
    input  logic                           d_i,
    input  logic [1:0]                     plv_i,
    input  logic [19:0]                    lookup_vppn_i,
    output logic                           found_o,
    output logic                           v_o,
    output logic                           d_o,
    output logic [1:0]                     plv_o,
    output logic [19:0]                    ppn_o
);

    logic [TLB_ENTRIES-1:0] used_q;
    logic [TLB_ENTRIES-1:0] v_q;
    logic [TLB_ENTRIES-1:0] d_q;
    logic [19:0]            vppn_q [TLB_ENTRIES];
    logic [19:0]            ppn_q  [TLB_ENTRIES];
    logic [1:0]             plv_q  [TLB_ENTRIES];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            used_q <= '0;
        end else if (we_i) begin
            used_q[idx_i] <= 1'b1; // entry holds a mapping, valid or not.
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            vppn_q[idx_i] <= vppn_i;
            ppn_q[idx_i]  <= ppn_i;
            v_q[idx_i]    <= v_i;
            d_q[idx_i]    <= d_i;
            plv_q[idx_i]  <= plv_i;
        end
    end

    // **************************************************
    // parallel compare, lowest index wins
    // **************************************************
    always_comb begin
        found_o = 1'b0;
        v_o     = 1'b0;
        d_o     = 1'b0;
        plv_o   = 2'd0;
        ppn_o   = 20'd0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (used_q[i] && vppn_q[i] == lookup_vppn_i) begin
                found_o = 1'b1;
                v_o     = v_q[i];
                d_o     = d_q[i];
                plv_o   = plv_q[i];
                ppn_o   = ppn_q[i];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/data_addr_check.sv */
`default_nettype none

module data_addr_check (
    input  logic [mem_pkg::OP_W-1:0]   op_i,
    input  logic [31:0]                vaddr_i,
    input  logic                       crmd_da_i,
    input  logic                       crmd_pg_i,
    input  logic [1:0]                 crmd_plv_i,
    input  logic [31:0]                dmw0_i,
    input  logic [31:0]                dmw1_i,
    input  logic                       tlb_found_i,
    input  logic                       tlb_v_i,
    input  logic                       tlb_d_i,
    input  logic [1:0]                 tlb_plv_i,
    input  logic [19:0]                tlb_ppn_i,
    output logic [31:0]                paddr_o,
    output logic [mem_pkg::EXCP_W-1:0] excp_num_o
);

    import mem_pkg::*;

    logic load_op;
    logic store_op;
    logic access_mem;
    logic half_op;
    logic word_op;
    logic pg_mode;
    logic dmw0_hit;
    logic dmw1_hit;
    logic trans_en;
    logic perm_ok;

    function automatic logic dmw_match(input logic [31:0] dmw, input logic [1:0] plv,
                                       input logic [2:0] vseg);
        logic plv_ok;
        plv_ok = (dmw[DMW_PLV0] && plv == 2'd0) || (dmw[DMW_PLV3] && plv == 2'd3);
        return plv_ok && dmw[DMW_VSEG_LSB +: 3] == vseg;
    endfunction

    assign load_op    = op_i inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL};
    assign store_op   = op_i inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
    assign access_mem = load_op || store_op;
    assign half_op    = op_i inside {OP_LD_H, OP_LD_HU, OP_ST_H};
    assign word_op    = op_i inside {OP_LD_W, OP_ST_W, OP_LL, OP_SC};

    // windows are only looked at when paging is on.
    assign pg_mode  = !crmd_da_i && crmd_pg_i;
    assign dmw0_hit = pg_mode && dmw_match(dmw0_i, crmd_plv_i, vaddr_i[31:29]);
    assign dmw1_hit = pg_mode && dmw_match(dmw1_i, crmd_plv_i, vaddr_i[31:29]);
    assign trans_en = pg_mode && !dmw0_hit && !dmw1_hit;
    assign perm_ok  = crmd_plv_i <= tlb_plv_i;

    always_comb begin
        if (trans_en) begin
            paddr_o = {tlb_ppn_i, vaddr_i[11:0]};
        end else if (dmw0_hit) begin
            paddr_o = {dmw0_i[DMW_PSEG_LSB +: 3], vaddr_i[28:0]}; // dmw0 has priority.
        end else if (dmw1_hit) begin
            paddr_o = {dmw1_i[DMW_PSEG_LSB +: 3], vaddr_i[28:0]};
        end else begin
            paddr_o = vaddr_i;
        end
    end

    always_comb begin
        excp_num_o            = '0;
        excp_num_o[EXCP_ALE]  = (half_op && vaddr_i[0]) || (word_op && vaddr_i[1:0] != 2'b00);
        excp_num_o[EXCP_TLBR] = access_mem && trans_en && !tlb_found_i;
        excp_num_o[EXCP_PIL]  = load_op && trans_en && tlb_found_i && !tlb_v_i;
        excp_num_o[EXCP_PIS]  = store_op && trans_en && tlb_found_i && !tlb_v_i;
        excp_num_o[EXCP_PPI]  = access_mem && trans_en && tlb_found_i && tlb_v_i && !perm_ok;
        excp_num_o[EXCP_PME]  = store_op && trans_en && tlb_found_i && tlb_v_i && perm_ok
                                && !tlb_d_i;
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`default_nettype none

module mem_stage (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  logic [mem_pkg::OP_W-1:0]   op_i,
    input  logic [31:0]                vaddr_i,
    input  logic [31:0]                wdata_i,
    output logic                       ack_o,
    output logic [31:0]                rdata_o,
    output logic                       wreg_o,
    output logic                       excp_o,
    output logic [mem_pkg::EXCP_W-1:0] excp_num_o,
    output logic [mem_pkg::OP_W-1:0]   chk_op_o,
    output logic [31:0]                chk_vaddr_o,
    input  logic [31:0]                paddr_i,
    input  logic [mem_pkg::EXCP_W-1:0] chk_excp_i,
    output logic                       ram_req_o,
    output logic                       ram_we_o,
    output logic [3:0]                 ram_be_o,
    output logic [31:0]                ram_addr_o,
    output logic [31:0]                ram_wdata_o,
    input  logic                       ram_ack_i,
    input  logic [31:0]                ram_rdata_i
);

    import mem_pkg::*;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_ISSUE   = 3'd1;
    localparam logic [2:0] S_RAM_ACK = 3'd2;
    localparam logic [2:0] S_RAM_REL = 3'd3;
    localparam logic [2:0] S_ANSWER  = 3'd4;

    logic [2:0]      state_q;
    logic [OP_W-1:0] op_q;
    logic [31:0]     vaddr_q;
    logic [31:0]     wdata_q;
    logic            ll_bit_q;
    logic            accept;
    logic            has_excp;
    logic            writes_reg;
    logic            skip_ram;
    mem_word_u       st_word;
    mem_word_u       ld_word;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [31:0]     ld_result;

    assign accept      = state_q == S_IDLE && req_i && !ack_o;
    assign chk_op_o    = op_q;
    assign chk_vaddr_o = vaddr_q;

    assign has_excp   = |chk_excp_i;
    assign writes_reg = !has_excp
                        && op_q inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL, OP_SC};
    assign skip_ram   = has_excp || op_q == OP_NOP || (op_q == OP_SC && !ll_bit_q);

    // **************************************************
    // lane placement, address 0 is the top byte
    // **************************************************
    assign ram_addr_o  = paddr_i;
    assign ram_we_o    = op_q inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
    assign ram_wdata_o = st_word;

    always_comb begin
        st_word  = wdata_q;
        ram_be_o = 4'b1111;
        case (op_q)
            OP_ST_B, OP_LD_B, OP_LD_BU: begin
                st_word.b = {4{wdata_q[7:0]}};
                ram_be_o  = 4'b1000 >> vaddr_q[1:0];
            end
            OP_ST_H, OP_LD_H, OP_LD_HU: begin
                st_word.h = {2{wdata_q[15:0]}};
                ram_be_o  = vaddr_q[1] ? 4'b0011 : 4'b1100;
            end
            default: ;
        endcase
    end

    assign ld_word = ram_rdata_i;
    assign ld_byte = ld_word.b[~vaddr_q[1:0]];
    assign ld_half = ld_word.h[~vaddr_q[1]];

    always_comb begin
        case (op_q)
            OP_LD_B:        ld_result = {{24{ld_byte[7]}}, ld_byte};
            OP_LD_BU:       ld_result = {24'd0, ld_byte};
            OP_LD_H:        ld_result = {{16{ld_half[15]}}, ld_half};
            OP_LD_HU:       ld_result = {16'd0, ld_half};
            OP_LD_W, OP_LL: ld_result = ld_word;
            OP_SC:          ld_result = 32'd1; // sc stored.
            default:        ld_result = 32'd0;
        endcase
    end

    // **************************************************
    // handshake sequencer
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            ack_o     <= 1'b0;
            ram_req_o <= 1'b0;
            ll_bit_q  <= 1'b0;
            wreg_o    <= 1'b0;
            excp_o    <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    wreg_o <= writes_reg;
                    excp_o <= has_excp;
                    if (!has_excp && op_q == OP_LL) begin
                        ll_bit_q <= 1'b1;
                    end
                    if (!has_excp && op_q == OP_SC) begin
                        ll_bit_q <= 1'b0; // any sc ends the reservation.
                    end
                    if (skip_ram) begin
                        ack_o   <= 1'b1;
                        state_q <= S_ANSWER;
                    end else begin
                        ram_req_o <= 1'b1;
                        state_q   <= S_RAM_ACK;
                    end
                end
                S_RAM_ACK: begin
                    if (ram_ack_i) begin
                        ram_req_o <= 1'b0;
                        ack_o     <= 1'b1;
                        state_q   <= S_RAM_REL;
                    end
                end
                S_RAM_REL: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                    end
                    if (!ram_ack_i) begin
                        state_q <= (req_i && ack_o) ? S_ANSWER : S_IDLE;
                    end
                end
                S_ANSWER: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= op_i;
            vaddr_q <= vaddr_i;
            wdata_q <= wdata_i;
        end
        if (state_q == S_ISSUE) begin
            excp_num_o <= chk_excp_i;
            rdata_o    <= 32'd0; // failed sc answers zero.
        end
        if (state_q == S_RAM_ACK && ram_ack_i) begin
            rdata_o <= ld_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`default_nettype none

module data_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [3:0]            be_i,
    input  logic [RAM_ADDR_W-1:0] addr_i,
    input  logic [31:0]           wdata_i,
    output logic                  ack_o,
    output logic [31:0]           rdata_o
);

    import mem_pkg::*;

    logic [31:0] mem_q [2**RAM_ADDR_W];
    mem_word_u   old_word;
    mem_word_u   new_word;
    mem_word_u   in_word;

    assign old_word = mem_q[addr_i];
    assign in_word  = wdata_i;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            new_word.b[i] = be_i[i] ? in_word.b[i] : old_word.b[i];
        end
    end

    // ack follows req one cycle late in both directions.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !ack_o) begin
            if (we_i) begin
                mem_q[addr_i] <= new_word;
            end
            rdata_o <= old_word; // held while ack is high.
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_top.sv */
`default_nettype none

module mem_top #(
    parameter int TLB_ENTRIES = 4,
    parameter int RAM_ADDR_W  = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           req_i,
    input  logic [mem_pkg::OP_W-1:0]       op_i,
    input  logic [31:0]                    vaddr_i,
    input  logic [31:0]                    wdata_i,
    output logic                           ack_o,
    output logic [31:0]                    rdata_o,
    output logic                           wreg_o,
    output logic                           excp_o,
    output logic [mem_pkg::EXCP_W-1:0]     excp_num_o,
    input  logic                           crmd_da_i,
    input  logic                           crmd_pg_i,
    input  logic [1:0]                     crmd_plv_i,
    input  logic [31:0]                    dmw0_i,
    input  logic [31:0]                    dmw1_i,
    input  logic                           tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_i,
    input  logic [19:0]                    tlb_vppn_i,
    input  logic [19:0]                    tlb_ppn_i,
    input  logic                           tlb_v_i,
    input  logic                           tlb_d_i,
    input  logic [1:0]                     tlb_plv_i
);

    import mem_pkg::*;

    logic [OP_W-1:0]       chk_op;
    logic [31:0]           chk_vaddr;
    logic [31:0]           paddr;
    logic [EXCP_W-1:0]     chk_excp;
    logic                  tlb_found;
    logic                  tlb_v;
    logic                  tlb_d;
    logic [1:0]            tlb_plv;
    logic [19:0]           tlb_ppn;
    logic                  ram_req;
    logic                  ram_we;
    logic [3:0]            ram_be;
    logic [31:0]           ram_paddr;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [31:0]           ram_wdata;
    logic                  ram_ack;
    logic [31:0]           ram_rdata;

    assign ram_addr = ram_paddr[RAM_ADDR_W+1:2]; // word index.

    // **************************************************
    // stage and translation
    // **************************************************
    mem_stage i_mem_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .vaddr_i     (vaddr_i),
        .wdata_i     (wdata_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .wreg_o      (wreg_o),
        .excp_o      (excp_o),
        .excp_num_o  (excp_num_o),
        .chk_op_o    (chk_op),
        .chk_vaddr_o (chk_vaddr),
        .paddr_i     (paddr),
        .chk_excp_i  (chk_excp),
        .ram_req_o   (ram_req),
        .ram_we_o    (ram_we),
        .ram_be_o    (ram_be),
        .ram_addr_o  (ram_paddr),
        .ram_wdata_o (ram_wdata),
        .ram_ack_i   (ram_ack),
        .ram_rdata_i (ram_rdata)
    );

    data_addr_check i_data_addr_check (
        .op_i        (chk_op),
        .vaddr_i     (chk_vaddr),
        .crmd_da_i   (crmd_da_i),
        .crmd_pg_i   (crmd_pg_i),
        .crmd_plv_i  (crmd_plv_i),
        .dmw0_i      (dmw0_i),
        .dmw1_i      (dmw1_i),
        .tlb_found_i (tlb_found),
        .tlb_v_i     (tlb_v),
        .tlb_d_i     (tlb_d),
        .tlb_plv_i   (tlb_plv),
        .tlb_ppn_i   (tlb_ppn),
        .paddr_o     (paddr),
        .excp_num_o  (chk_excp)
    );

    data_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_data_tlb (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .we_i          (tlb_we_i),
        .idx_i         (tlb_idx_i),
        .vppn_i        (tlb_vppn_i),
        .ppn_i         (tlb_ppn_i),
        .v_i           (tlb_v_i),
        .d_i           (tlb_d_i),
        .plv_i         (tlb_plv_i),
        .lookup_vppn_i (chk_vaddr[31:12]),
        .found_o       (tlb_found),
        .v_o           (tlb_v),
        .d_o           (tlb_d),
        .plv_o         (tlb_plv),
        .ppn_o         (tlb_ppn)
    );

    data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) i_data_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .ack_o   (ram_ack),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

/* tb/tb_mem_top.sv */
`default_nettype none

module tb_mem_top;

    import mem_pkg::*;

    localparam int MAX_VEC     = 64;
    localparam int VEC_WORDS   = 8;
    localparam int RAND_WORDS  = 16;
    localparam int CYC_PER_VEC = 20;

    localparam logic [31:0] KIND_TLB = 32'h1;
    localparam logic [31:0] KIND_END = 32'hf;
    localparam logic [3:0]  CSR_DA   = 4'h1;
    localparam logic [31:0] DMW0_CFG = 32'ha000_0001; // vseg 5, pseg 0, plv0 only.
    localparam logic [31:0] DMW1_CFG = 32'h8200_0008; // vseg 4, pseg 1, plv3 only.

    logic              clk;
    logic              rst_n;
    logic              req;
    logic [OP_W-1:0]   op;
    logic [31:0]       vaddr;
    logic [31:0]       wdata;
    logic              ack;
    logic [31:0]       rdata;
    logic              wreg;
    logic              excp;
    logic [EXCP_W-1:0] excp_num;
    logic              crmd_da;
    logic              crmd_pg;
    logic [1:0]        crmd_plv;
    logic [31:0]       dmw0;
    logic [31:0]       dmw1;
    logic              tlb_we;
    logic [1:0]        tlb_idx;
    logic [19:0]       tlb_vppn;
    logic [19:0]       tlb_ppn;
    logic              tlb_v;
    logic              tlb_d;
    logic [1:0]        tlb_plv;

    logic [31:0] vec_mem [MAX_VEC*VEC_WORDS];
    logic [31:0] ref_mem [256];
    logic [7:0]  rand_idx [RAND_WORDS];
    int          n_vec;
    int          n_tests;
    int          n_failed;
    logic        loaded;
    integer      seed;

    mem_top #(
        .TLB_ENTRIES (4),
        .RAM_ADDR_W  (8)
    ) i_mem_top (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .op_i       (op),
        .vaddr_i    (vaddr),
        .wdata_i    (wdata),
        .ack_o      (ack),
        .rdata_o    (rdata),
        .wreg_o     (wreg),
        .excp_o     (excp),
        .excp_num_o (excp_num),
        .crmd_da_i  (crmd_da),
        .crmd_pg_i  (crmd_pg),
        .crmd_plv_i (crmd_plv),
        .dmw0_i     (dmw0),
        .dmw1_i     (dmw1),
        .tlb_we_i   (tlb_we),
        .tlb_idx_i  (tlb_idx),
        .tlb_vppn_i (tlb_vppn),
        .tlb_ppn_i  (tlb_ppn),
        .tlb_v_i    (tlb_v),
        .tlb_d_i    (tlb_d),
        .tlb_plv_i  (tlb_plv)
    );

    always #5 clk = ~clk;

    // **************************************************
    // stimulus tasks
    // **************************************************
    task automatic write_tlb(input int base);
        @(negedge clk);
        tlb_we   = 1'b1;
        tlb_idx  = vec_mem[base+1][1:0];
        tlb_v    = vec_mem[base+2][0];
        tlb_d    = vec_mem[base+2][1];
        tlb_plv  = vec_mem[base+2][3:2];
        tlb_vppn = vec_mem[base+3][19:0];
        tlb_ppn  = vec_mem[base+4][19:0];
        @(negedge clk);
        tlb_we = 1'b0;
        $display("tlb entry %0d loaded, vppn %h", tlb_idx, tlb_vppn);
    endtask

    task automatic run_access(input logic [3:0] csr, input logic [OP_W-1:0] a_op,
                              input logic [31:0] a_addr, input logic [31:0] a_wdata,
                              input logic [31:0] exp_rdata, input logic exp_wreg,
                              input logic [EXCP_W-1:0] exp_excp);
        logic bad;
        bad = 1'b0;
        @(negedge clk);
        crmd_da  = csr[0];
        crmd_pg  = csr[1];
        crmd_plv = csr[3:2];
        op       = a_op;
        vaddr    = a_addr;
        wdata    = a_wdata;
        req      = 1'b1;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        if (rdata !== exp_rdata) begin
            $display("[ERROR] %0t rdata_o got %h expected %h", $time, rdata, exp_rdata);
            bad = 1'b1;
        end
        if (wreg !== exp_wreg) begin
            $display("[ERROR] %0t wreg_o got %b expected %b", $time, wreg, exp_wreg);
            bad = 1'b1;
        end
        if (excp_num !== exp_excp) begin
            $display("[ERROR] %0t excp_num_o got %h expected %h", $time, excp_num, exp_excp);
            bad = 1'b1;
        end
        if (excp !== (exp_excp != '0)) begin
            $display("[ERROR] %0t excp_o got %b expected %b", $time, excp, exp_excp != '0);
            bad = 1'b1;
        end
        req = 1'b0; // release, then wait for ack to drop.
        @(negedge clk);
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
        n_tests++;
        if (bad) begin
            n_failed++;
            $display("test %0d op %0h addr %h: wrong result", n_tests, a_op, a_addr);
        end else begin
            $display("test %0d op %0h addr %h: ok", n_tests, a_op, a_addr);
        end
    endtask

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        int          base;
        logic [31:0] rnd;
        logic [7:0]  widx;
        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = 1'b0;
        op       = OP_NOP;
        vaddr    = 32'd0;
        wdata    = 32'd0;
        crmd_da  = 1'b1;
        crmd_pg  = 1'b0;
        crmd_plv = 2'd0;
        dmw0     = DMW0_CFG;
        dmw1     = DMW1_CFG;
        tlb_we   = 1'b0;
        tlb_idx  = 2'd0;
        tlb_vppn = 20'd0;
        tlb_ppn  = 20'd0;
        tlb_v    = 1'b0;
        tlb_d    = 1'b0;
        tlb_plv  = 2'd0;
        seed     = 32'h8b2a_fee7;
        n_tests  = 0;
        n_failed = 0;
        n_vec    = 0;
        $readmemh("tb/mem_input.txt", vec_mem);
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_WORDS] !== KIND_END) begin
            n_vec++;
        end
        if (n_vec == MAX_VEC) begin
            $display("vector file has no end marker");
            n_failed++;
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int v = 0; v < n_vec; v++) begin
            base = v * VEC_WORDS;
            if (vec_mem[base] == KIND_TLB) begin
                write_tlb(base);
            end else begin
                run_access(vec_mem[base+1][3:0], vec_mem[base+2][OP_W-1:0], vec_mem[base+3],
                           vec_mem[base+4], vec_mem[base+5], vec_mem[base+6][0],
                           vec_mem[base+7][EXCP_W-1:0]);
            end
        end

        // random words in da mode, checked against a local copy.
        for (int i = 0; i < RAND_WORDS; i++) begin
            rnd           = $random(seed);
            widx          = rnd[7:0];
            rnd           = $random(seed);
            ref_mem[widx] = rnd;
            rand_idx[i]   = widx;
            run_access(CSR_DA, OP_ST_W, {22'd0, widx, 2'b00}, rnd, 32'd0, 1'b0, '0);
        end
        for (int i = 0; i < RAND_WORDS; i++) begin
            widx = rand_idx[i];
            run_access(CSR_DA, OP_LD_W, {22'd0, widx, 2'b00}, 32'd0, ref_mem[widx], 1'b1, '0);
        end

        $display("tests run %0d, failed %0d", n_tests, n_failed);
        if (n_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // budget of 20 cycles per vector and per random access.
    initial begin
        int limit;
        wait (loaded === 1'b1);
        limit = (n_vec + 2 * RAND_WORDS) * CYC_PER_VEC + 10;
        repeat (limit) @(posedge clk);
        $display("timeout, the accesses did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/mem_input.txt */
// access: 0 csr{plv[3:2],pg,da} op vaddr wdata exp_rdata exp_wreg exp_excp
// tlb write: 1 idx flags{plv[3:2],d,v} vppn ppn 0 0 0, and kind f ends the list
0 1 8 00000100 11223344 00000000 0 00
0 1 6 00000101 000000ab 00000000 0 00
0 1 7 00000102 0000cdef 00000000 0 00
0 1 5 00000100 00000000 11abcdef 1 00
0 1 1 00000101 00000000 ffffffab 1 00
0 1 2 00000101 00000000 000000ab 1 00
0 1 3 00000102 00000000 ffffcdef 1 00
0 1 4 00000100 00000000 000011ab 1 00
0 e 8 80000010 cafef00d 00000000 0 00
0 2 5 a0000010 00000000 cafef00d 1 00
0 2 5 80000010 00000000 00000000 0 02
1 0 f 00400 00000 0 0 0
1 1 e 00401 00000 0 0 0
1 2 d 00402 00000 0 0 0
1 3 3 00403 00000 0 0 0
0 e 8 00400020 5a5a1234 00000000 0 00
0 e 5 00400020 00000000 5a5a1234 1 00
0 e 5 00401000 00000000 00000000 0 20
0 e 8 00401000 0badf00d 00000000 0 10
0 e 8 00402000 0badf00d 00000000 0 04
0 e 5 00403000 00000000 00000000 0 08
0 1 7 00000101 0000ffff 00000000 0 01
0 1 8 00000102 ffffffff 00000000 0 01
0 1 5 00000100 00000000 11abcdef 1 00
0 1 a 00000100 77777777 00000000 1 00
0 1 9 00000100 00000000 11abcdef 1 00
0 1 a 00000100 77777777 00000001 1 00
0 1 a 00000100 88888888 00000000 1 00
0 1 5 00000100 00000000 77777777 1 00
f 0 0 0 0 0 0 0

/* mem_top.f */
verilog/mem_pkg.sv
verilog/data_tlb.sv
verilog/data_addr_check.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/mem_top.sv
tb/tb_mem_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_mem_top -f mem_top.f -o tb_mem_top > build.log 2>&1 \
    && ./obj_dir/tb_mem_top | tee sim.log \
    || { echo "build or simulation failed, see build.log"; exit 1; }

grep -qx "All checks passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

exit 0
